// File: common/fetch_pkg.sv
// Types shared by the fetch unit and the decode side of the core.
package fetch_pkg;

    // One instruction as it is handed to decode.
    typedef struct packed {
        logic [31:0] pc;    // address of the instruction.
        logic [31:0] inst;  // instruction word, zero when faulted.
        logic        fault; // set when the bus returned an error.
    } fetch_packet_t;

    // Next-PC request from the execute stage.
    typedef struct packed {
        logic        valid;  // replace the sequential PC.
        logic [31:0] target; // new fetch address.
    } redirect_t;

    // Fetch FSM states.
    typedef enum logic [1:0] {
        idle = 2'd0, // looking up the cache with the current PC.
        busy = 2'd1, // block refill in progress on the bus.
        hold = 2'd2  // faulted packet waits for decode.
    } fetch_state_e;

endpackage

// File: common/axi_pkg.sv
// AXI read channel types used by the fetch unit.
package axi_pkg;

    // Burst type encodings.
    typedef enum logic [1:0] {
        burst_fixed = 2'b00,
        burst_incr  = 2'b01
    } axi_burst_e;

    // Read response encodings.
    typedef enum logic [1:0] {
        resp_okay   = 2'b00,
        resp_exokay = 2'b01,
        resp_slverr = 2'b10,
        resp_decerr = 2'b11
    } axi_resp_e;

    // Transfer size code for one 32-bit word.
    localparam logic [2:0] size_word = 3'd2;

    // Read address channel payload.
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  id;
        logic [7:0]  len;   // beats minus one.
        logic [2:0]  size;
        axi_burst_e  burst;
    } axi_ar_t;

    // Read data channel payload, one beat.
    typedef struct packed {
        logic [31:0] data;
        axi_resp_e   resp;
        logic        last;
        logic [3:0]  id;
    } axi_r_t;

endpackage

// File: fetch/icache.sv
`timescale 1ns/1ps

module icache #(
    parameter int block_bytes = 16,
    parameter int sets        = 8
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [31:0]              lookup_addr,
    output logic                     hit,
    output logic [31:0]              hit_inst,
    input  logic                     fill_valid,
    input  logic [31:0]              fill_addr,
    input  logic [block_bytes*8-1:0] fill_block
);
    localparam int off_w  = $clog2(block_bytes);
    localparam int idx_w  = $clog2(sets);
    localparam int tag_w  = 32 - off_w - idx_w;
    localparam int sel_w  = (idx_w > 0) ? idx_w : 1;
    localparam int word_w = (off_w > 2) ? off_w - 2 : 1;

    logic [block_bytes*8-1:0] data_q [sets];
    logic [tag_w-1:0]         tag_q  [sets];
    logic [sets-1:0]          valid_q;

    logic [sel_w-1:0]  lk_idx;
    logic [tag_w-1:0]  lk_tag;
    logic [word_w-1:0] lk_word;
    logic [sel_w-1:0]  fl_idx;

    // line index of an address, zero when there is a single line.
    function automatic logic [sel_w-1:0] idx_of(input logic [31:0] addr);
        return sel_w'((addr >> off_w) & 32'(sets - 1));
    endfunction

    function automatic logic [tag_w-1:0] tag_of(input logic [31:0] addr);
        return addr[31 -: tag_w];
    endfunction

    assign lk_idx  = idx_of(lookup_addr);
    assign lk_tag  = tag_of(lookup_addr);
    assign lk_word = word_w'((lookup_addr & 32'(block_bytes - 1)) >> 2);
    assign fl_idx  = idx_of(fill_addr);

    assign hit      = valid_q[lk_idx] && (tag_q[lk_idx] == lk_tag);
    assign hit_inst = data_q[lk_idx][lk_word*32 +: 32];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            valid_q <= '0;
        end else if (fill_valid) begin
            valid_q[fl_idx] <= 1'b1;
        end
    end

    // the whole line is replaced, there is no partial fill.
    always_ff @(posedge clk) begin
        if (fill_valid) begin
            data_q[fl_idx] <= fill_block;
            tag_q[fl_idx]  <= tag_of(fill_addr);
        end
    end

    a_fill_aligned: assert property (@(posedge clk) disable iff (rst)
        fill_valid |-> (fill_addr & 32'(block_bytes - 1)) == 32'd0);

endmodule

// File: fetch/ifu.sv
`timescale 1ns/1ps

module ifu #(
    parameter int          block_bytes = 16,
    parameter logic [31:0] reset_pc    = 32'h3000_0000,
    parameter logic [31:0] sdram_base  = 32'hA000_0000,
    parameter logic [31:0] sdram_end   = 32'hBFFF_FFFF
) (
    input  logic                       clk,
    input  logic                       rst,
    input  fetch_pkg::redirect_t       redirect,
    output logic                       out_valid,
    input  logic                       out_ready,
    output fetch_pkg::fetch_packet_t   out_packet,
    output logic                       ar_valid,
    input  logic                       ar_ready,
    output axi_pkg::axi_ar_t           ar,
    input  logic                       r_valid,
    output logic                       r_ready,
    input  axi_pkg::axi_r_t            r,
    output logic [31:0]                lookup_addr,
    input  logic                       hit,
    input  logic [31:0]                hit_inst,
    output logic                       fill_valid,
    output logic [31:0]                fill_addr,
    output logic [block_bytes*8-1:0]   fill_block
);
    import fetch_pkg::*;
    import axi_pkg::*;

    localparam int words = block_bytes / 4;
    localparam int cnt_w = $clog2(words) + 1;

    fetch_state_e             state;
    logic [31:0]              pc;
    logic [31:0]              next_pc;
    logic [31:0]              blk_base;
    logic                     in_sdram;
    logic [cnt_w-1:0]         beat_cnt;
    logic                     faulted;  // an earlier beat of this burst failed.
    logic [block_bytes*8-1:0] line_buf;

    logic slot_free;
    logic issue_hit;
    logic miss_start;
    logic beat;
    logic beat_err;
    logic burst_mode;
    logic last_beat;
    logic refill_done;
    logic next_req;

    assign next_pc  = redirect.valid ? redirect.target : pc + 32'd4;
    assign blk_base = pc & ~32'(block_bytes - 1);
    assign in_sdram = (blk_base >= sdram_base) && (blk_base <= sdram_end);

    // a new packet may be loaded once the current one is gone or leaves this cycle.
    assign slot_free  = !out_valid || out_ready;
    assign issue_hit  = (state == idle) && slot_free && hit;
    // the cycle of a fill pulse still sees the old tags, so no miss starts there.
    assign miss_start = (state == idle) && slot_free && !hit && !fill_valid;

    assign beat        = (state == busy) && r_valid && r_ready;
    assign beat_err    = faulted || (r.resp == resp_slverr) || (r.resp == resp_decerr);
    assign burst_mode  = (ar.burst == burst_incr);
    assign last_beat   = (beat_cnt == cnt_w'(words - 1));
    // single reads stop at the first error, a burst is drained to its end.
    assign refill_done = beat && (last_beat || (beat_err && !burst_mode));
    assign next_req    = beat && !refill_done && !burst_mode;

    assign lookup_addr = pc;
    assign fill_addr   = blk_base;
    assign fill_block  = line_buf;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= idle;
            pc         <= reset_pc;
            out_valid  <= 1'b0;
            ar_valid   <= 1'b0;
            r_ready    <= 1'b0;
            fill_valid <= 1'b0;
            beat_cnt   <= '0;
            faulted    <= 1'b0;
        end else begin
            fill_valid <= 1'b0;
            if (out_valid && out_ready) begin
                out_valid <= 1'b0;
            end
            case (state)
                idle: begin
                    if (issue_hit) begin
                        out_valid <= 1'b1;
                        pc        <= next_pc;
                    end else if (miss_start) begin
                        ar_valid <= 1'b1;
                        beat_cnt <= '0;
                        faulted  <= 1'b0;
                        state    <= busy;
                    end
                end
                busy: begin
                    if (ar_valid && ar_ready) begin
                        ar_valid <= 1'b0;
                        r_ready  <= 1'b1;
                    end
                    if (refill_done) begin
                        r_ready  <= 1'b0;
                        beat_cnt <= '0;
                        if (beat_err) begin
                            out_valid <= 1'b1; // faulted packet skips the cache.
                            pc        <= next_pc;
                            state     <= hold;
                        end else begin
                            fill_valid <= 1'b1;
                            state      <= idle;
                        end
                    end else if (beat) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        faulted  <= beat_err;
                        if (next_req) begin
                            ar_valid <= 1'b1;
                        end
                    end
                end
                hold: begin
                    if (out_ready) begin
                        state <= idle;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue_hit) begin
            out_packet <= '{pc: pc, inst: hit_inst, fault: 1'b0};
        end else if (refill_done && beat_err) begin
            out_packet <= '{pc: pc, inst: 32'h0, fault: 1'b1};
        end

        if (miss_start) begin
            ar <= '{addr:  blk_base,
                    id:    4'd0,
                    len:   in_sdram ? 8'(words - 1) : 8'd0,
                    size:  size_word,
                    burst: in_sdram ? burst_incr : burst_fixed};
        end else if (next_req) begin
            ar.addr <= ar.addr + 32'd4; // next word of the block.
        end

        if (beat) begin
            line_buf[beat_cnt*32 +: 32] <= r.data;
        end
    end

    a_ar_stable: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !ar_ready |=> ar_valid && $stable(ar));

    a_r_ready_busy: assert property (@(posedge clk) disable iff (rst)
        r_ready |-> state == busy);

    a_beat_range: assert property (@(posedge clk) disable iff (rst)
        32'(beat_cnt) < words);

endmodule

// File: hdl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
    parameter int          block_bytes = 16,
    parameter int          sets        = 8,
    parameter logic [31:0] reset_pc    = 32'h3000_0000,
    parameter logic [31:0] sdram_base  = 32'hA000_0000,
    parameter logic [31:0] sdram_end   = 32'hBFFF_FFFF
) (
    input  logic                     clk,
    input  logic                     rst,
    input  fetch_pkg::redirect_t     redirect,
    output logic                     out_valid,
    input  logic                     out_ready,
    output fetch_pkg::fetch_packet_t out_packet,
    output logic                     ar_valid,
    input  logic                     ar_ready,
    output axi_pkg::axi_ar_t         ar,
    input  logic                     r_valid,
    output logic                     r_ready,
    input  axi_pkg::axi_r_t          r
);
    logic [31:0]              lookup_addr;
    logic                     hit;
    logic [31:0]              hit_inst;
    logic                     fill_valid;
    logic [31:0]              fill_addr;
    logic [block_bytes*8-1:0] fill_block;

    ifu #(
        .block_bytes (block_bytes),
        .reset_pc    (reset_pc),
        .sdram_base  (sdram_base),
        .sdram_end   (sdram_end)
    ) i_ifu (
        .clk         (clk),
        .rst         (rst),
        .redirect    (redirect),
        .out_valid   (out_valid),
        .out_ready   (out_ready),
        .out_packet  (out_packet),
        .ar_valid    (ar_valid),
        .ar_ready    (ar_ready),
        .ar          (ar),
        .r_valid     (r_valid),
        .r_ready     (r_ready),
        .r           (r),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_inst    (hit_inst),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_block  (fill_block)
    );

    icache #(
        .block_bytes (block_bytes),
        .sets        (sets)
    ) i_icache (
        .clk         (clk),
        .rst         (rst),
        .lookup_addr (lookup_addr),
        .hit         (hit),
        .hit_inst    (hit_inst),
        .fill_valid  (fill_valid),
        .fill_addr   (fill_addr),
        .fill_block  (fill_block)
    );

endmodule

// File: bench/axi_mem_responder.sv
`timescale 1ns/1ps

module axi_mem_responder #(
    parameter logic [31:0] fault_lo = 32'h3000_0100,
    parameter logic [31:0] fault_hi = 32'h3000_010F,
    parameter logic [31:0] seed     = 32'd45
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             ar_valid,
    output logic             ar_ready = 1'b0,
    input  axi_pkg::axi_ar_t ar,
    output logic             r_valid = 1'b0,
    input  logic             r_ready,
    output axi_pkg::axi_r_t  r = '0
);
    import axi_pkg::*;

    logic        live  = 1'b0;
    logic        ar_hs = 1'b0;
    logic        r_hs  = 1'b0;
    axi_ar_t     ar_q  = '0;
    logic        busy  = 1'b0;
    logic [31:0] addr  = '0;
    logic [7:0]  left  = '0; // beats owed after the current one.
    logic        incr  = 1'b0;
    logic [31:0] rand_state = seed;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // memory word at address a, with an error response inside the fault window.
    function automatic axi_r_t beat_for(input logic [31:0] a, input logic last);
        axi_r_t b;
        b.data = a ^ 32'h5A5A_0000;
        b.resp = (a >= fault_lo && a <= fault_hi) ? resp_slverr : resp_okay;
        b.last = last;
        b.id   = 4'd0;
        return b;
    endfunction

    // handshakes are seen on the rising edge and acted on at the falling edge.
    always @(posedge clk) begin
        live  <= !rst;
        ar_hs <= ar_valid && ar_ready;
        r_hs  <= r_valid && r_ready;
        ar_q  <= ar;
    end

    always @(negedge clk) begin
        rand_state <= xorshift(rand_state);
        if (!live) begin
            busy     <= 1'b0;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
        end else if (ar_hs) begin
            busy     <= 1'b1;
            addr     <= ar_q.addr;
            left     <= ar_q.len;
            incr     <= (ar_q.burst == burst_incr);
            ar_ready <= 1'b0;
        end else if (busy) begin
            if (r_hs) begin
                r_valid <= 1'b0;
                if (left == 8'd0) begin
                    busy <= 1'b0;
                end else begin
                    left <= left - 8'd1;
                    if (incr) begin
                        addr <= addr + 32'd4;
                    end
                end
            end else if (!r_valid && (rand_state[5] || rand_state[9])) begin
                r_valid <= 1'b1; // a raised beat stays until it is taken.
                r       <= beat_for(addr, left == 8'd0);
            end
        end else begin
            ar_ready <= rand_state[3] || rand_state[7];
        end
    end

endmodule

// File: bench/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;
    import fetch_pkg::*;
    import axi_pkg::*;

    localparam int          block_bytes = 16;
    localparam int          sets        = 8;
    localparam logic [31:0] sdram_base  = 32'hA000_0000;
    localparam logic [31:0] sdram_end   = 32'hBFFF_FFFF;
    localparam logic [31:0] fault_lo    = 32'h3000_0100;
    localparam logic [31:0] fault_hi    = 32'h3000_010F;
    localparam int          n_pkts      = 26; // 8 + 2 + 4 faulted + 4 sdram + 8.
    localparam int          max_cycles  = 5000;

    logic          clk = 1'b0;
    logic          rst = 1'b1;
    redirect_t     redirect = '0;
    logic          out_ready = 1'b0;
    logic          out_valid;
    fetch_packet_t out_packet;
    logic          ar_valid;
    logic          ar_ready;
    axi_ar_t       ar;
    logic          r_valid;
    logic          r_ready;
    axi_r_t        r;

    logic [31:0] pc_model   = 32'h3000_0000; // pc register of the DUT as the program sees it.
    logic [31:0] pkt_pc     = '0;            // pc expected in the packet now presented.
    logic [31:0] rand_state = 32'd45;
    logic        live       = 1'b0;
    logic        prev_free  = 1'b0;
    redirect_t   prev_redir = '0;
    logic        r_ready_q  = 1'b0;
    logic [31:0] last_ar_addr = '0;
    logic [31:0] refill_blk   = '0;
    logic        refill_err   = 1'b0;
    logic [31:0] shadow_tag [sets];
    logic [sets-1:0] shadow_valid = '0;
    int          errors     = 0;
    int          accepted   = 0;
    int          ar_count   = 0;
    int          fault_ars  = 0;
    int          fault_pkts = 0;
    logic        new_pkt;
    logic        ar_hs;
    logic        ar_resident;
    logic [31:0] exp_ar_addr;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic in_sdram(input logic [31:0] a);
        return (a >= sdram_base) && (a <= sdram_end);
    endfunction

    function automatic logic in_fault(input logic [31:0] a);
        return (a >= fault_lo) && (a <= fault_hi);
    endfunction

    function automatic int line_of(input logic [31:0] a);
        return int'((a / block_bytes) % sets);
    endfunction

    function automatic logic [31:0] tag_of(input logic [31:0] a);
        return a / (block_bytes * sets);
    endfunction

    // branches of the test program, keyed by the pc that jumps.
    function automatic redirect_t jump_for(input logic [31:0] pc);
        redirect_t j;
        j.valid = 1'b1;
        case (pc)
            32'h3000_001C: j.target = 32'h3000_00F8;
            32'h3000_010C: j.target = sdram_base;
            32'hA000_000C: j.target = 32'h3000_0000;
            default:       j = '0;
        endcase
        return j;
    endfunction

    fetch_top #(
        .block_bytes (block_bytes),
        .sets        (sets),
        .reset_pc    (32'h3000_0000),
        .sdram_base  (sdram_base),
        .sdram_end   (sdram_end)
    ) i_fetch_top (
        .clk        (clk),
        .rst        (rst),
        .redirect   (redirect),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_packet (out_packet),
        .ar_valid   (ar_valid),
        .ar_ready   (ar_ready),
        .ar         (ar),
        .r_valid    (r_valid),
        .r_ready    (r_ready),
        .r          (r)
    );

    axi_mem_responder #(
        .fault_lo (fault_lo),
        .fault_hi (fault_hi),
        .seed     (32'd45)
    ) i_mem (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar       (ar),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r        (r)
    );

    // a packet loaded on the last edge is one that found the slot free.
    assign new_pkt     = out_valid && prev_free;
    assign ar_hs       = ar_valid && ar_ready;
    assign ar_resident = shadow_valid[line_of(ar.addr)]
                         && (shadow_tag[line_of(ar.addr)] == tag_of(ar.addr));
    assign exp_ar_addr = r_ready ? last_ar_addr + 32'd4 : pc_model & ~32'(block_bytes - 1);

    initial begin
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        live       <= !rst;
        prev_free  <= !out_valid || out_ready;
        prev_redir <= redirect;
        r_ready_q  <= r_ready;
        if (out_valid && out_ready) begin
            accepted <= accepted + 1;
        end
        if (ar_hs) begin
            ar_count     <= ar_count + 1;
            last_ar_addr <= ar.addr;
            if (!r_ready) begin
                refill_blk <= ar.addr; // first request of a refill.
                refill_err <= 1'b0;
                if (in_fault(ar.addr)) begin
                    fault_ars <= fault_ars + 1;
                end
            end
        end
        if (r_valid && r_ready && r.resp != resp_okay) begin
            refill_err <= 1'b1;
        end
        if (r_ready_q && !r_ready && !refill_err) begin
            shadow_tag[line_of(refill_blk)] <= tag_of(refill_blk);
            shadow_valid[line_of(refill_blk)] <= 1'b1;
        end
        if (new_pkt && out_packet.fault) begin
            fault_pkts <= fault_pkts + 1;
        end
    end

    always @(negedge clk) begin
        if (live) begin
            if (new_pkt) begin
                pkt_pc   = pc_model;
                pc_model = prev_redir.valid ? prev_redir.target : pc_model + 32'd4;
            end
            rand_state = xorshift(rand_state);
            out_ready  = (rand_state[1:0] != 2'd0);
            redirect   = jump_for(pc_model); // held until the pc moves on.
        end
    end

    initial begin
        int cycles;
        cycles = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        while (accepted < n_pkts && cycles < max_cycles) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        if (accepted < n_pkts) begin
            $display("timeout while waiting for %0d accepted packets, only %0d arrived",
                     n_pkts, accepted);
            errors = errors + 1;
        end
        $display("errors %0d, packets %0d, ar requests %0d, faulted packets %0d",
                 errors, accepted, ar_count, fault_pkts);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    a_pkt_pc: assert property (@(posedge clk) disable iff (rst)
        new_pkt |-> out_packet.pc == pkt_pc)
        else begin
            errors = errors + 1;
            $display("Error: out_packet.pc is %h, expected %h", $sampled(out_packet.pc), pkt_pc);
        end

    a_pkt_inst: assert property (@(posedge clk) disable iff (rst)
        new_pkt && !out_packet.fault |-> out_packet.inst == (pkt_pc ^ 32'h5A5A_0000))
        else begin
            errors = errors + 1;
            $display("Error: out_packet.inst is %h, expected %h",
                     $sampled(out_packet.inst), pkt_pc ^ 32'h5A5A_0000);
        end

    a_pkt_fault: assert property (@(posedge clk) disable iff (rst)
        new_pkt |-> out_packet.fault == in_fault(pkt_pc))
        else begin
            errors = errors + 1;
            $display("Error: out_packet.fault is %h, expected %h",
                     $sampled(out_packet.fault), in_fault(pkt_pc));
        end

    a_stall: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_packet))
        else begin
            errors = errors + 1;
            $display("the packet changed or vanished while decode held out_ready low");
        end

    a_ar_id: assert property (@(posedge clk) disable iff (rst)
        ar_valid |-> ar.id == 4'd0)
        else begin
            errors = errors + 1;
            $display("Error: ar.id is %h, expected 0", $sampled(ar.id));
        end

    a_single_req: assert property (@(posedge clk) disable iff (rst)
        ar_valid && !in_sdram(ar.addr) |->
            ar.len == 8'd0 && ar.burst == burst_fixed && ar.size == 3'd2)
        else begin
            errors = errors + 1;
            $display("Error: ar.len/ar.burst/ar.size are %h/%h/%h, expected 00/0/2",
                     $sampled(ar.len), $sampled(ar.burst), $sampled(ar.size));
        end

    a_single_addr: assert property (@(posedge clk) disable iff (rst)
        ar_hs && !in_sdram(ar.addr) |-> ar.addr == exp_ar_addr)
        else begin
            errors = errors + 1;
            $display("Error: ar.addr is %h, expected %h", $sampled(ar.addr), exp_ar_addr);
        end

    a_burst_req: assert property (@(posedge clk) disable iff (rst)
        ar_hs && in_sdram(ar.addr) |-> !r_ready && ar.addr == exp_ar_addr
            && ar.len == 8'(block_bytes / 4 - 1) && ar.burst == burst_incr)
        else begin
            errors = errors + 1;
            $display("Error: ar.addr/ar.len/ar.burst are %h/%h/%h, expected %h/%h/1",
                     $sampled(ar.addr), $sampled(ar.len), $sampled(ar.burst),
                     exp_ar_addr, 8'(block_bytes / 4 - 1));
        end

    a_fault_refetch: assert property (@(posedge clk) disable iff (rst)
        new_pkt && out_packet.fault |-> fault_ars == fault_pkts + 1)
        else begin
            errors = errors + 1;
            $display("Error: fault_ars is %h, expected %h", fault_ars, fault_pkts + 1);
        end

    a_no_refetch: assert property (@(posedge clk) disable iff (rst)
        ar_hs && !r_ready |-> !ar_resident)
        else begin
            errors = errors + 1;
            $display("a refill was requested for block %h although it is still cached",
                     $sampled(ar.addr));
        end

endmodule

// File: filelist.f
common/fetch_pkg.sv
common/axi_pkg.sv
fetch/icache.sv
fetch/ifu.sv
hdl/fetch_top.sv
bench/axi_mem_responder.sv
bench/tb_fetch.sv

// File: run_sim.sh
#!/bin/sh
# Builds the fetch testbench with Verilator and runs it into sim.log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
{ verilator --binary --timing --assert -Wno-fatal -j 0 \
    --top-module tb_fetch -Mdir obj_dir -f filelist.f \
    && ./obj_dir/Vtb_fetch; } > sim.log 2>&1 \
    || echo "sim failed" >> sim.log
grep -q "sim failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } \
    || { echo "PASS"; exit 0; }
